// File: design/ooo_mem_pkg.sv
// ####################
// Shared widths, memory size and shuffle seed
// Response status and command class enums
// ####################

package ooo_mem_pkg;

    // Word address and data widths
    localparam int ADDR_WIDTH = 10;
    localparam int DATA_WIDTH = 32;

    // Request and response tag width
    localparam int USER_WIDTH = 8;

    // Populated words; addresses at or above this are out of range
    localparam int MEM_WORDS = 768;

    // Reset value of the rotating shuffle pattern
    localparam logic [19:0] SHUFFLE_SEED = 20'h8676d;

    // Response status, encoded as on the Avalon-MM response field
    typedef enum logic [1:0]
    {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } t_resp;

    // Command class handed from the input side to the memory
    typedef enum logic [1:0]
    {
        cmd_none   = 2'b00,
        cmd_access = 2'b01,
        cmd_reject = 2'b10
    } t_cmd;

endpackage

// File: design/avalon_cmd_stage.sv
// ####################
// Input side of the memory responder
// Registers read and write commands, range check
// ####################

`timescale 1ns/10ps

module avalon_cmd_stage
(
    input  logic                                clk,
    input  logic                                reset_n,

    // Read command from the host
    input  logic                                rd_read,
    input  logic [ooo_mem_pkg::ADDR_WIDTH-1:0]  rd_address,
    input  logic [ooo_mem_pkg::USER_WIDTH-1:0]  rd_user,

    // Write command from the host
    input  logic                                wr_write,
    input  logic [ooo_mem_pkg::ADDR_WIDTH-1:0]  wr_address,
    input  logic [ooo_mem_pkg::DATA_WIDTH-1:0]  wr_writedata,
    input  logic [ooo_mem_pkg::USER_WIDTH-1:0]  wr_user,

    // Registered commands toward the memory
    output ooo_mem_pkg::t_cmd                   rd_cmd,
    output logic [ooo_mem_pkg::ADDR_WIDTH-1:0]  rd_addr_q,
    output logic [ooo_mem_pkg::USER_WIDTH-1:0]  rd_user_q,
    output ooo_mem_pkg::t_cmd                   wr_cmd,
    output logic [ooo_mem_pkg::ADDR_WIDTH-1:0]  wr_addr_q,
    output logic [ooo_mem_pkg::DATA_WIDTH-1:0]  wr_data_q,
    output logic [ooo_mem_pkg::USER_WIDTH-1:0]  wr_user_q
);

    ooo_mem_pkg::t_cmd rd_class;
    ooo_mem_pkg::t_cmd wr_class;

    // Classify each strobe against the populated range
    always_comb
    begin
        rd_class = ooo_mem_pkg::cmd_none;
        if (rd_read)
        begin
            rd_class = (rd_address < ooo_mem_pkg::MEM_WORDS) ?
                       ooo_mem_pkg::cmd_access : ooo_mem_pkg::cmd_reject;
        end

        wr_class = ooo_mem_pkg::cmd_none;
        if (wr_write)
        begin
            wr_class = (wr_address < ooo_mem_pkg::MEM_WORDS) ?
                       ooo_mem_pkg::cmd_access : ooo_mem_pkg::cmd_reject;
        end
    end

    // Command class registers
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rd_cmd <= ooo_mem_pkg::cmd_none;
            wr_cmd <= ooo_mem_pkg::cmd_none;
        end
        else
        begin
            rd_cmd <= rd_class;
            wr_cmd <= wr_class;
        end
    end

    // Payload follows the strobe every cycle, qualified by the class
    always_ff @(posedge clk)
    begin
        rd_addr_q <= rd_address;
        rd_user_q <= rd_user;
        wr_addr_q <= wr_address;
        wr_data_q <= wr_writedata;
        wr_user_q <= wr_user;
    end

endmodule

// File: design/mem_array_model.sv
// ####################
// Memory array model
// Read data and status, write acknowledge
// ####################

`timescale 1ns/10ps

module mem_array_model
(
    input  logic                                clk,
    input  logic                                reset_n,

    // Registered commands from the input side
    input  ooo_mem_pkg::t_cmd                   rd_cmd,
    input  logic [ooo_mem_pkg::ADDR_WIDTH-1:0]  rd_addr_q,
    input  logic [ooo_mem_pkg::USER_WIDTH-1:0]  rd_user_q,
    input  ooo_mem_pkg::t_cmd                   wr_cmd,
    input  logic [ooo_mem_pkg::ADDR_WIDTH-1:0]  wr_addr_q,
    input  logic [ooo_mem_pkg::DATA_WIDTH-1:0]  wr_data_q,
    input  logic [ooo_mem_pkg::USER_WIDTH-1:0]  wr_user_q,

    // Read response
    output logic [ooo_mem_pkg::DATA_WIDTH-1:0]  rd_rsp_data,
    output ooo_mem_pkg::t_resp                  rd_rsp_status,
    output logic [ooo_mem_pkg::USER_WIDTH-1:0]  rd_rsp_user,
    output logic                                rd_rsp_valid,

    // Write response
    output ooo_mem_pkg::t_resp                  wr_rsp_status,
    output logic [ooo_mem_pkg::USER_WIDTH-1:0]  wr_rsp_user,
    output logic                                wr_rsp_valid
);

    logic [ooo_mem_pkg::DATA_WIDTH-1:0] mem [ooo_mem_pkg::MEM_WORDS];

    // Storage powers up cleared
    initial
    begin
        for (int i = 0; i < ooo_mem_pkg::MEM_WORDS; i++)
        begin
            mem[i] = '0;
        end
    end

    // Only in-range writes reach the array
    always @(posedge clk)
    begin
        if (wr_cmd == ooo_mem_pkg::cmd_access)
        begin
            mem[wr_addr_q] <= wr_data_q;
        end
    end

    // Read path; a same-cycle write to the same word is not yet visible here
    always_ff @(posedge clk)
    begin
        if (rd_cmd == ooo_mem_pkg::cmd_access)
        begin
            rd_rsp_data   <= mem[rd_addr_q];
            rd_rsp_status <= ooo_mem_pkg::resp_okay;
        end
        else
        begin
            rd_rsp_data   <= '0;
            rd_rsp_status <= ooo_mem_pkg::resp_slverr;
        end
        rd_rsp_user <= rd_user_q;

        wr_rsp_status <= (wr_cmd == ooo_mem_pkg::cmd_reject) ?
                         ooo_mem_pkg::resp_slverr : ooo_mem_pkg::resp_okay;
        wr_rsp_user   <= wr_user_q;
    end

    // One response per accepted command
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rd_rsp_valid <= 1'b0;
            wr_rsp_valid <= 1'b0;
        end
        else
        begin
            rd_rsp_valid <= (rd_cmd != ooo_mem_pkg::cmd_none);
            wr_rsp_valid <= (wr_cmd != ooo_mem_pkg::cmd_none);
        end
    end

endmodule

// File: design/ooo_resp_shuffle.sv
// ####################
// Two-slot response shuffler
// Slot choice from a rotating 20-bit pattern
// ####################

`timescale 1ns/10ps

module ooo_resp_shuffle
#(
    // Packed response width, valid in bit 0
    parameter int WIDTH = 1
)
(
    input  logic             clk,
    input  logic             reset_n,
    input  logic [WIDTH-1:0] data_in,
    output logic [WIDTH-1:0] data_out
);

    logic [19:0]      pattern;
    logic [WIDTH-1:0] slot0;
    logic [WIDTH-1:0] slot1;

    // Fixed bit pattern rotated left each cycle
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            pattern <= ooo_mem_pkg::SHUFFLE_SEED;
        else
            pattern <= {pattern[18:0], pattern[19]};
    end

    // The selected slot drains and refills in the same cycle, so nothing is dropped
    always_ff @(posedge clk)
    begin
        if (pattern[0])
        begin
            slot0    <= data_in;
            data_out <= slot0;
        end
        else
        begin
            slot1    <= data_in;
            data_out <= slot1;
        end

        // Only the valid bits need clearing
        if (!reset_n)
        begin
            slot0[0]    <= 1'b0;
            slot1[0]    <= 1'b0;
            data_out[0] <= 1'b0;
        end
    end

endmodule

// File: design/ooo_mem_top.sv
// ####################
// Memory responder top level
// Command stage, memory array, optional shufflers
// ####################

`timescale 1ns/10ps

module ooo_mem_top
#(
    // 0 for in-order responses, 1 to shuffle them
    parameter int OUT_OF_ORDER = 0
)
(
    input  logic                                clk,
    input  logic                                reset_n,

    // Read channel
    input  logic                                rd_read,
    input  logic [ooo_mem_pkg::ADDR_WIDTH-1:0]  rd_address,
    input  logic [ooo_mem_pkg::USER_WIDTH-1:0]  rd_user,
    output logic [ooo_mem_pkg::DATA_WIDTH-1:0]  rd_readdata,
    output ooo_mem_pkg::t_resp                  rd_response,
    output logic [ooo_mem_pkg::USER_WIDTH-1:0]  rd_readresponseuser,
    output logic                                rd_readdatavalid,

    // Write channel
    input  logic                                wr_write,
    input  logic [ooo_mem_pkg::ADDR_WIDTH-1:0]  wr_address,
    input  logic [ooo_mem_pkg::DATA_WIDTH-1:0]  wr_writedata,
    input  logic [ooo_mem_pkg::USER_WIDTH-1:0]  wr_user,
    output ooo_mem_pkg::t_resp                  wr_response,
    output logic [ooo_mem_pkg::USER_WIDTH-1:0]  wr_writeresponseuser,
    output logic                                wr_writeresponsevalid
);

    localparam int RESP_BITS = $bits(ooo_mem_pkg::t_resp);
    localparam int RD_WIDTH  = ooo_mem_pkg::DATA_WIDTH + RESP_BITS +
                               ooo_mem_pkg::USER_WIDTH + 1;
    localparam int WR_WIDTH  = RESP_BITS + ooo_mem_pkg::USER_WIDTH + 1;

    // Registered commands
    ooo_mem_pkg::t_cmd                  rd_cmd;
    logic [ooo_mem_pkg::ADDR_WIDTH-1:0] rd_addr_q;
    logic [ooo_mem_pkg::USER_WIDTH-1:0] rd_user_q;
    ooo_mem_pkg::t_cmd                  wr_cmd;
    logic [ooo_mem_pkg::ADDR_WIDTH-1:0] wr_addr_q;
    logic [ooo_mem_pkg::DATA_WIDTH-1:0] wr_data_q;
    logic [ooo_mem_pkg::USER_WIDTH-1:0] wr_user_q;

    // Responses straight from the memory
    logic [ooo_mem_pkg::DATA_WIDTH-1:0] rd_rsp_data;
    ooo_mem_pkg::t_resp                 rd_rsp_status;
    logic [ooo_mem_pkg::USER_WIDTH-1:0] rd_rsp_user;
    logic                               rd_rsp_valid;
    ooo_mem_pkg::t_resp                 wr_rsp_status;
    logic [ooo_mem_pkg::USER_WIDTH-1:0] wr_rsp_user;
    logic                               wr_rsp_valid;

    avalon_cmd_stage cmd0
    (
        .clk, .reset_n,
        .rd_read, .rd_address, .rd_user,
        .wr_write, .wr_address, .wr_writedata, .wr_user,
        .rd_cmd, .rd_addr_q, .rd_user_q,
        .wr_cmd, .wr_addr_q, .wr_data_q, .wr_user_q
    );

    mem_array_model mem0
    (
        .clk, .reset_n,
        .rd_cmd, .rd_addr_q, .rd_user_q,
        .wr_cmd, .wr_addr_q, .wr_data_q, .wr_user_q,
        .rd_rsp_data, .rd_rsp_status, .rd_rsp_user, .rd_rsp_valid,
        .wr_rsp_status, .wr_rsp_user, .wr_rsp_valid
    );

    generate
        if (OUT_OF_ORDER == 0)
        begin : g_in_order
            assign rd_readdata           = rd_rsp_data;
            assign rd_response           = rd_rsp_status;
            assign rd_readresponseuser   = rd_rsp_user;
            assign rd_readdatavalid      = rd_rsp_valid;
            assign wr_response           = wr_rsp_status;
            assign wr_writeresponseuser  = wr_rsp_user;
            assign wr_writeresponsevalid = wr_rsp_valid;
        end
        else
        begin : g_out_of_order
            logic [RD_WIDTH-1:0] rd_shuf_out;
            logic [WR_WIDTH-1:0] wr_shuf_out;

            // Valid rides in bit 0 of each packed word
            ooo_resp_shuffle #(.WIDTH(RD_WIDTH)) rd_shuf
            (
                .clk, .reset_n,
                .data_in({rd_rsp_data, rd_rsp_status, rd_rsp_user, rd_rsp_valid}),
                .data_out(rd_shuf_out)
            );

            ooo_resp_shuffle #(.WIDTH(WR_WIDTH)) wr_shuf
            (
                .clk, .reset_n,
                .data_in({wr_rsp_status, wr_rsp_user, wr_rsp_valid}),
                .data_out(wr_shuf_out)
            );

            assign {rd_readdata, rd_readresponseuser} =
                {rd_shuf_out[RD_WIDTH-1 -: ooo_mem_pkg::DATA_WIDTH],
                 rd_shuf_out[ooo_mem_pkg::USER_WIDTH:1]};
            assign rd_response =
                ooo_mem_pkg::t_resp'(rd_shuf_out[ooo_mem_pkg::USER_WIDTH+1 +: RESP_BITS]);
            assign rd_readdatavalid = rd_shuf_out[0];

            assign wr_response =
                ooo_mem_pkg::t_resp'(wr_shuf_out[WR_WIDTH-1 -: RESP_BITS]);
            assign wr_writeresponseuser  = wr_shuf_out[ooo_mem_pkg::USER_WIDTH:1];
            assign wr_writeresponsevalid = wr_shuf_out[0];
        end
    endgenerate

endmodule

// File: tb/ooo_mem_properties.sv
// ####################
// Concurrent assertions on the responder outputs
// Bound into ooo_mem_top
// ####################

`timescale 1ns/10ps

module ooo_mem_properties
#(
    parameter int OUT_OF_ORDER = 0
)
(
    input  logic               clk,
    input  logic               reset_n,
    input  logic               rd_read,
    input  ooo_mem_pkg::t_resp rd_response,
    input  logic               rd_readdatavalid,
    input  logic               wr_writeresponsevalid
);

    // Both channels come out of reset idle
    a_idle_after_reset: assert property (@(posedge clk)
        $rose(reset_n) |-> !rd_readdatavalid && !wr_writeresponsevalid)
        else $error("response valid high in the cycle after reset");

    // Status is only meaningful together with its valid
    a_legal_read_resp: assert property (@(posedge clk) disable iff (!reset_n)
        rd_readdatavalid |->
            rd_response inside {ooo_mem_pkg::resp_okay, ooo_mem_pkg::resp_slverr})
        else $error("illegal read response code");

    generate
        if (OUT_OF_ORDER == 0)
        begin : g_bypass
            // Fixed two-cycle latency without the shufflers
            a_read_latency: assert property (@(posedge clk) disable iff (!reset_n)
                rd_read |-> ##2 rd_readdatavalid)
                else $error("no read valid two cycles after the read strobe");
        end
    endgenerate

endmodule

bind ooo_mem_top ooo_mem_properties #(.OUT_OF_ORDER(OUT_OF_ORDER)) props0
(
    .clk(clk),
    .reset_n(reset_n),
    .rd_read(rd_read),
    .rd_response(rd_response),
    .rd_readdatavalid(rd_readdatavalid),
    .wr_writeresponsevalid(wr_writeresponsevalid)
);

// File: tb/tb_ooo_mem.sv
// ####################
// Testbench for the memory responder
// Clock, reset, stimulus, reference memory
// Tag scoreboard and check task
// ####################

`timescale 1ns/10ps

module tb_ooo_mem;

    // 1 runs the shufflers, 0 the in-order bypass
    parameter int OUT_OF_ORDER = 1;

    localparam int AW            = ooo_mem_pkg::ADDR_WIDTH;
    localparam int TAGS          = 1 << ooo_mem_pkg::USER_WIDTH;
    localparam int RANDOM_CYCLES = 400;
    localparam int DRAIN_LIMIT   = 200;

    logic                               clk;
    logic                               reset_n;
    logic                               rd_read;
    logic [AW-1:0]                      rd_address;
    logic [ooo_mem_pkg::USER_WIDTH-1:0] rd_user;
    logic [ooo_mem_pkg::DATA_WIDTH-1:0] rd_readdata;
    ooo_mem_pkg::t_resp                 rd_response;
    logic [ooo_mem_pkg::USER_WIDTH-1:0] rd_readresponseuser;
    logic                               rd_readdatavalid;
    logic                               wr_write;
    logic [AW-1:0]                      wr_address;
    logic [ooo_mem_pkg::DATA_WIDTH-1:0] wr_writedata;
    logic [ooo_mem_pkg::USER_WIDTH-1:0] wr_user;
    ooo_mem_pkg::t_resp                 wr_response;
    logic [ooo_mem_pkg::USER_WIDTH-1:0] wr_writeresponseuser;
    logic                               wr_writeresponsevalid;

    // Reference memory and per-tag expectations
    logic [ooo_mem_pkg::DATA_WIDTH-1:0] ref_mem [ooo_mem_pkg::MEM_WORDS];
    logic                               rd_pending [TAGS];
    logic [ooo_mem_pkg::DATA_WIDTH-1:0] rd_exp_data [TAGS];
    ooo_mem_pkg::t_resp                 rd_exp_resp [TAGS];
    int                                 rd_seq [TAGS];
    logic                               wr_pending [TAGS];
    ooo_mem_pkg::t_resp                 wr_exp_resp [TAGS];
    int                                 wr_seq [TAGS];
    logic [ooo_mem_pkg::USER_WIDTH-1:0] rd_tag;
    logic [ooo_mem_pkg::USER_WIDTH-1:0] wr_tag;
    int                                 rd_issued;
    int                                 rd_received;
    int                                 wr_issued;
    int                                 wr_received;
    int                                 rd_last_seq;
    int                                 wr_last_seq;
    logic                               ooo_seen;
    integer                             seed;

    ooo_mem_top #(.OUT_OF_ORDER(OUT_OF_ORDER)) dut0
    (
        .clk, .reset_n,
        .rd_read, .rd_address, .rd_user,
        .rd_readdata, .rd_response, .rd_readresponseuser, .rd_readdatavalid,
        .wr_write, .wr_address, .wr_writedata, .wr_user,
        .wr_response, .wr_writeresponseuser, .wr_writeresponsevalid
    );

    always #20 clk = ~clk;

    task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                         input string what);
        if (actual !== expected)
        begin
            $display("ERROR at %0t: %s, got %0h expected %0h", $time, what, actual, expected);
            $display("Errors found");
            $fatal(1, "check failed");
        end
    endtask

    // Expected read result as {status, data}, from the memory state before this cycle
    function automatic logic [33:0] ref_read(input logic [AW-1:0] addr);
        if (addr < ooo_mem_pkg::MEM_WORDS)
            return {ooo_mem_pkg::resp_okay, ref_mem[addr]};
        return {ooo_mem_pkg::resp_slverr, 32'h0};
    endfunction

    // Out-of-range writes leave the reference untouched
    function automatic ooo_mem_pkg::t_resp ref_write(input logic [AW-1:0] addr,
                                                     input logic [31:0] data);
        if (addr >= ooo_mem_pkg::MEM_WORDS)
            return ooo_mem_pkg::resp_slverr;
        ref_mem[addr] = data;
        return ooo_mem_pkg::resp_okay;
    endfunction

    // One address in eight above the populated range
    function automatic logic [AW-1:0] rand_addr();
        int unsigned u;
        u = $unsigned($random(seed));
        if ((u & 7) == 0)
            return AW'(ooo_mem_pkg::MEM_WORDS + (u >> 3) % ((1 << AW) - ooo_mem_pkg::MEM_WORDS));
        // Small window half the time so reads hit recent writes
        if (u[30])
            return AW'((u >> 3) % 32);
        return AW'((u >> 3) % ooo_mem_pkg::MEM_WORDS);
    endfunction

    task automatic issue(input logic do_rd, input logic [AW-1:0] ra,
                         input logic do_wr, input logic [AW-1:0] wa,
                         input logic [31:0] wd);
        logic [33:0] exp_rd;
        @(negedge clk);
        rd_read      = do_rd;
        rd_address   = ra;
        rd_user      = rd_tag;
        wr_write     = do_wr;
        wr_address   = wa;
        wr_writedata = wd;
        wr_user      = wr_tag;
        // Read first, so a write in the same cycle is not seen
        if (do_rd)
        begin
            check(rd_pending[rd_tag], 1'b0, "read tag still outstanding");
            exp_rd = ref_read(ra);
            rd_exp_resp[rd_tag] = ooo_mem_pkg::t_resp'(exp_rd[33:32]);
            rd_exp_data[rd_tag] = exp_rd[31:0];
            rd_seq[rd_tag]      = rd_issued;
            rd_pending[rd_tag]  = 1'b1;
            rd_issued++;
            rd_tag++;
        end
        if (do_wr)
        begin
            check(wr_pending[wr_tag], 1'b0, "write tag still outstanding");
            wr_exp_resp[wr_tag] = ref_write(wa, wd);
            wr_seq[wr_tag]      = wr_issued;
            wr_pending[wr_tag]  = 1'b1;
            wr_issued++;
            wr_tag++;
        end
    endtask

    // Idle cycles with the valid outputs checked for stray responses
    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++)
        begin
            @(negedge clk);
            rd_read  = 1'b0;
            wr_write = 1'b0;
            check(rd_readdatavalid, 1'b0, "read valid while idle");
            check(wr_writeresponsevalid, 1'b0, "write valid while idle");
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while ((rd_received != rd_issued || wr_received != wr_issued) && waited < DRAIN_LIMIT)
        begin
            @(negedge clk);
            rd_read  = 1'b0;
            wr_write = 1'b0;
            waited++;
        end
        if (rd_received != rd_issued || wr_received != wr_issued)
        begin
            $display("Timeout: %0d read and %0d write responses never arrived",
                     rd_issued - rd_received, wr_issued - wr_received);
            $display("Errors found");
            $fatal(1, "response timeout");
        end
    endtask

    // Scoreboard matched by tag
    always @(posedge clk)
    begin
        if (reset_n && rd_readdatavalid)
        begin
            check(rd_pending[rd_readresponseuser], 1'b1, "unknown or repeated read tag");
            check(rd_readdata, rd_exp_data[rd_readresponseuser], "read data");
            check(rd_response, rd_exp_resp[rd_readresponseuser], "read response");
            rd_pending[rd_readresponseuser] = 1'b0;
            if (rd_seq[rd_readresponseuser] < rd_last_seq)
                ooo_seen = 1'b1;
            else
                rd_last_seq = rd_seq[rd_readresponseuser];
            rd_received++;
        end
        if (reset_n && wr_writeresponsevalid)
        begin
            check(wr_pending[wr_writeresponseuser], 1'b1, "unknown or repeated write tag");
            check(wr_response, wr_exp_resp[wr_writeresponseuser], "write response");
            wr_pending[wr_writeresponseuser] = 1'b0;
            if (wr_seq[wr_writeresponseuser] < wr_last_seq)
                ooo_seen = 1'b1;
            else
                wr_last_seq = wr_seq[wr_writeresponseuser];
            wr_received++;
        end
    end

    initial
    begin
        seed = 32'heafbb94f;
        clk = 1'b0;
        reset_n = 1'b0;
        rd_read = 1'b0;
        rd_address = '0;
        rd_user = '0;
        wr_write = 1'b0;
        wr_address = '0;
        wr_writedata = '0;
        wr_user = '0;
        rd_tag = '0;
        wr_tag = '0;
        rd_issued = 0;
        rd_received = 0;
        wr_issued = 0;
        wr_received = 0;
        rd_last_seq = -1;
        wr_last_seq = -1;
        ooo_seen = 1'b0;
        for (int i = 0; i < ooo_mem_pkg::MEM_WORDS; i++)
            ref_mem[i] = '0;
        for (int t = 0; t < TAGS; t++)
        begin
            rd_pending[t] = 1'b0;
            wr_pending[t] = 1'b0;
        end

        // Three reset cycles, then two quiet ones
        idle_cycles(3);
        reset_n = 1'b1;
        idle_cycles(2);

        // Write then read back an in-range word
        issue(1'b0, '0, 1'b1, 10'd5, 32'hcafe_0005);
        issue(1'b1, 10'd5, 1'b0, '0, '0);
        // Out-of-range write must not alias onto word 132
        issue(1'b0, '0, 1'b1, 10'd132, 32'h1234_0132);
        issue(1'b0, '0, 1'b1, 10'd900, 32'hdead_0900);
        issue(1'b1, 10'd900, 1'b0, '0, '0);
        issue(1'b1, 10'd132, 1'b0, '0, '0);
        // Same-cycle read and write of one word
        issue(1'b1, 10'd132, 1'b1, 10'd132, 32'h5555_aaaa);
        issue(1'b1, 10'd132, 1'b0, '0, '0);
        drain();

        for (int i = 0; i < RANDOM_CYCLES; i++)
            issue(($random(seed) & 7) != 0, rand_addr(), ($random(seed) & 7) != 0,
                  rand_addr(), $random(seed));
        drain();
        idle_cycles(20);

        if (OUT_OF_ORDER != 0)
            check(ooo_seen, 1'b1, "no response overtook an earlier one");
        $display("No errors");
        $finish;
    end

endmodule

// File: sim.f
design/ooo_mem_pkg.sv
design/avalon_cmd_stage.sv
design/mem_array_model.sv
design/ooo_resp_shuffle.sv
design/ooo_mem_top.sv
tb/ooo_mem_properties.sv
tb/tb_ooo_mem.sv

// File: Bender.yml
package:
  name: ooo_mem

sources:
  # Design sources in compile order
  - design/ooo_mem_pkg.sv
  - design/avalon_cmd_stage.sv
  - design/mem_array_model.sv
  - design/ooo_resp_shuffle.sv
  - design/ooo_mem_top.sv

  # Simulation only
  - target: test
    files:
      - tb/ooo_mem_properties.sv
      - tb/tb_ooo_mem.sv
